/* Bender.yml */
package:
  name: data_memory_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dmem_pkg.sv
      - rtl/mem_op_decode.sv
      - rtl/byte_bank.sv
      - rtl/striped_memory.sv
      - rtl/load_extend.sv
      - rtl/data_memory_unit.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tb/data_memory_unit_tb.sv

/* rtl/byte_bank.sv */
`timescale 1ns/10ps
`include "dmem_config.svh"

module byte_bank (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    enable,
	input  logic                    write,
	input  logic [`DMEM_LOG_MEM_BYTES-`DMEM_LOG_WORD_BYTES-1:0] index,
	input  dmem_pkg::byte_t         wdata,
	output dmem_pkg::byte_t         rdata
);

	localparam int ROWS = 2 ** (`DMEM_LOG_MEM_BYTES - `DMEM_LOG_WORD_BYTES);

	dmem_pkg::byte_t mem [ROWS];

	always_ff @(posedge clk) begin
		if (enable && write) begin
			mem[index] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rdata <= '0;
		end else if (enable && !write) begin
			rdata <= mem[index]; // held between reads
		end
	end

endmodule

/* rtl/data_memory_unit.sv */
`timescale 1ns/10ps

module data_memory_unit (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    req_valid,
	input  logic                    req_store,
	input  dmem_pkg::width_code_t   funct3,
	input  dmem_pkg::word_t         base,
	input  dmem_pkg::word_t         offset,
	input  dmem_pkg::word_t         store_data,
	output logic                    req_error,
	output logic                    load_valid,
	output dmem_pkg::word_t         load_data
);

	logic mem_enable;
	logic mem_write;
	dmem_pkg::addr_t mem_addr;
	dmem_pkg::size_t mem_size;
	logic load_signed;
	logic load_issue;
	dmem_pkg::word_t read_word;

	mem_op_decode u_decode (
		.req_valid   (req_valid),
		.req_store   (req_store),
		.funct3      (funct3),
		.base        (base),
		.offset      (offset),
		.mem_enable  (mem_enable),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_size    (mem_size),
		.load_signed (load_signed),
		.load_issue  (load_issue),
		.req_error   (req_error)
	);

	striped_memory u_execute (
		.clk    (clk),
		.reset  (reset),
		.enable (mem_enable),
		.write  (mem_write),
		.addr   (mem_addr),
		.size   (mem_size),
		.wdata  (store_data),
		.rdata  (read_word)
	);

	// size and sign are delayed inside to meet read_word
	load_extend u_result (
		.clk         (clk),
		.reset       (reset),
		.load_issue  (load_issue),
		.size        (mem_size),
		.load_signed (load_signed),
		.read_word   (read_word),
		.load_valid  (load_valid),
		.load_data   (load_data)
	);

endmodule

/* rtl/dmem_config.svh */
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// data word width
`define DMEM_WORD_BITS 32

// bytes per word, also the number of banks
`define DMEM_WORD_BYTES 4

`define DMEM_LOG_WORD_BYTES 2

// 1 KiB in total, 256 bytes per bank
`define DMEM_LOG_MEM_BYTES 10

`endif

/* rtl/dmem_pkg.sv */
`include "dmem_config.svh"

package dmem_pkg;

	typedef logic [`DMEM_WORD_BITS-1:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [31:0] addr_t;

	// access bytes minus one
	typedef logic [`DMEM_LOG_WORD_BYTES-1:0] size_t;

	typedef logic [2:0] width_code_t;

	// codes 3, 6 and 7 are illegal
	typedef enum logic [2:0] {
		FUNCT3_B  = 3'd0,
		FUNCT3_H  = 3'd1,
		FUNCT3_W  = 3'd2,
		FUNCT3_BU = 3'd4,
		FUNCT3_HU = 3'd5
	} funct3_e;

endpackage

/* rtl/load_extend.sv */
`timescale 1ns/10ps
`include "dmem_config.svh"

module load_extend (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load_issue,
	input  dmem_pkg::size_t         size,
	input  logic                    load_signed,
	input  dmem_pkg::word_t         read_word,
	output logic                    load_valid,
	output dmem_pkg::word_t         load_data
);

	dmem_pkg::size_t size_q;
	logic signed_q;
	logic fill;

	// lines up with the bank read data
	always_ff @(posedge clk) begin
		if (reset) begin
			load_valid <= 1'b0;
			size_q <= '0;
			signed_q <= 1'b0;
		end else begin
			load_valid <= load_issue;
			size_q <= size;
			signed_q <= load_signed;
		end
	end

	assign fill = signed_q && read_word[{size_q, 3'b111}]; // top kept bit

	always_comb begin
		for (int b = 0; b < `DMEM_WORD_BYTES; b++) begin
			if (b <= int'(size_q)) begin
				load_data[b*8 +: 8] = read_word[b*8 +: 8];
			end else begin
				load_data[b*8 +: 8] = {8{fill}};
			end
		end
	end

endmodule

/* rtl/mem_op_decode.sv */
`timescale 1ns/10ps
`include "dmem_config.svh"

module mem_op_decode (
	input  logic                    req_valid,
	input  logic                    req_store,
	input  dmem_pkg::width_code_t   funct3,
	input  dmem_pkg::word_t         base,
	input  dmem_pkg::word_t         offset,
	output logic                    mem_enable,
	output logic                    mem_write,
	output dmem_pkg::addr_t         mem_addr,
	output dmem_pkg::size_t         mem_size,
	output logic                    load_signed,
	output logic                    load_issue,
	output logic                    req_error
);

	dmem_pkg::word_t sum;
	logic legal;

	always_comb begin
		mem_size = '0;
		load_signed = 1'b0;
		legal = 1'b0;
		case (dmem_pkg::funct3_e'(funct3))
			dmem_pkg::FUNCT3_B: begin
				mem_size = 2'd0;
				load_signed = 1'b1;
				legal = 1'b1;
			end
			dmem_pkg::FUNCT3_H: begin
				mem_size = 2'd1;
				load_signed = 1'b1;
				legal = 1'b1;
			end
			dmem_pkg::FUNCT3_W: begin
				mem_size = 2'd3;
				legal = 1'b1;
			end
			dmem_pkg::FUNCT3_BU: begin
				mem_size = 2'd0;
				legal = !req_store; // no unsigned stores
			end
			dmem_pkg::FUNCT3_HU: begin
				mem_size = 2'd1;
				legal = !req_store;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign sum = base + offset;

	// wraps modulo the memory size
	assign mem_addr = dmem_pkg::addr_t'(sum[`DMEM_LOG_MEM_BYTES-1:0]);

	assign mem_enable = req_valid && legal;
	assign mem_write = req_store;
	assign load_issue = req_valid && legal && !req_store;
	assign req_error = req_valid && !legal;

endmodule

/* rtl/striped_memory.sv */
`timescale 1ns/10ps
`include "dmem_config.svh"

module striped_memory (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    enable,
	input  logic                    write,
	input  dmem_pkg::addr_t         addr,
	input  dmem_pkg::size_t         size,
	input  dmem_pkg::word_t         wdata,
	output dmem_pkg::word_t         rdata
);

	localparam int NB = `DMEM_WORD_BYTES;

	typedef logic [`DMEM_LOG_WORD_BYTES-1:0] lane_t;

	lane_t first_lane;
	lane_t last_lane;
	lane_t first_q;
	logic wrap;

	dmem_pkg::byte_t bank_rdata [NB];

	assign first_lane = lane_t'(addr[`DMEM_LOG_WORD_BYTES-1:0]);
	assign last_lane = first_lane + lane_t'(size); // modulo the bank count
	assign wrap = last_lane < first_lane;

	// rotation amount for the read data of the next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			first_q <= '0;
		end else begin
			first_q <= first_lane;
		end
	end

	for (genvar i = 0; i < NB; i++) begin : g_lane
		lane_t lane_off;
		logic lane_in;
		logic lane_on;
		dmem_pkg::addr_t lane_addr;

		// distance from the first lane, also the store byte for this bank
		assign lane_off = lane_t'(i) - first_lane;

		assign lane_in = wrap ?
			((first_lane <= lane_t'(i)) || (lane_t'(i) <= last_lane)) :
			((first_lane <= lane_t'(i)) && (lane_t'(i) <= last_lane));

		assign lane_on = enable && lane_in;

		// lanes past the wrap go to the next row
		assign lane_addr = addr + dmem_pkg::addr_t'(lane_off);

		byte_bank u_bank (
			.clk    (clk),
			.reset  (reset),
			.enable (lane_on),
			.write  (write),
			.index  (lane_addr[`DMEM_LOG_MEM_BYTES-1:`DMEM_LOG_WORD_BYTES]),
			.wdata  (wdata[lane_off*8 +: 8]),
			.rdata  (bank_rdata[i])
		);
	end

	for (genvar j = 0; j < NB; j++) begin : g_realign
		lane_t src;

		assign src = lane_t'(j) + first_q;
		assign rdata[j*8 +: 8] = bank_rdata[src]; // byte 0 is the lowest address
	end

endmodule

/* tb/data_memory_unit_tb.sv */
`timescale 1ns/10ps
`include "dmem_config.svh"

module data_memory_unit_tb;

	localparam int MEM_BYTES = 2 ** `DMEM_LOG_MEM_BYTES;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_store;
	dmem_pkg::width_code_t funct3;
	dmem_pkg::word_t base;
	dmem_pkg::word_t offset;
	dmem_pkg::word_t store_data;
	logic req_error;
	logic load_valid;
	dmem_pkg::word_t load_data;

	dmem_pkg::byte_t ref_mem [MEM_BYTES]; // reference byte array
	bit known [MEM_BYTES];                // byte has been written

	data_memory_unit u_data_memory_unit (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_store  (req_store),
		.funct3     (funct3),
		.base       (base),
		.offset     (offset),
		.store_data (store_data),
		.req_error  (req_error),
		.load_valid (load_valid),
		.load_data  (load_data)
	);

	always #4 clk = ~clk;

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input dmem_pkg::word_t expected,
			input dmem_pkg::word_t actual);
		assert (actual === expected) else begin
			$display("** Error: %s expected %h, got %h", name, expected, actual);
			stop_run();
		end
	endtask

	function automatic int access_bytes(input dmem_pkg::width_code_t code);
		case (code[1:0])
			2'd0: return 1;
			2'd1: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic int wrap_addr(input dmem_pkg::word_t base_v, input dmem_pkg::word_t off_v);
		return int'((base_v + off_v) & dmem_pkg::word_t'(MEM_BYTES - 1));
	endfunction

	// little-endian update
	function automatic void ref_store(input int addr, input dmem_pkg::width_code_t code,
			input dmem_pkg::word_t data);
		int idx;
		for (int i = 0; i < access_bytes(code); i++) begin
			idx = (addr + i) % MEM_BYTES;
			ref_mem[idx] = data[i*8 +: 8];
			known[idx] = 1'b1;
		end
	endfunction

	function automatic void ref_load(input int addr, input dmem_pkg::width_code_t code,
			output dmem_pkg::word_t value, output logic all_known);
		int n;
		int idx;
		n = access_bytes(code);
		value = '0;
		all_known = 1'b1;
		for (int i = 0; i < n; i++) begin
			idx = (addr + i) % MEM_BYTES;
			value[i*8 +: 8] = ref_mem[idx];
			if (!known[idx]) begin
				all_known = 1'b0;
			end
		end
		if (n < 4 && !code[2] && value[n*8-1]) begin
			value = value | (dmem_pkg::word_t'('1) << (n * 8)); // sign fill
		end
	endfunction

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			req_valid = 1'b0;
			req_store = 1'b0;
		end
	endtask

	task automatic wait_load_idle();
		int cycles;
		cycles = 0;
		while (load_valid !== 1'b0 && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		if (load_valid !== 1'b0) begin
			$display("timeout while waiting for load_valid to return low");
			stop_run();
		end
	endtask

	task automatic do_store(input dmem_pkg::width_code_t code, input dmem_pkg::word_t base_v,
			input dmem_pkg::word_t off_v, input dmem_pkg::word_t data, input logic illegal);
		@(negedge clk);
		req_valid = 1'b1;
		req_store = 1'b1;
		funct3 = code;
		base = base_v;
		offset = off_v;
		store_data = data;
		#1;
		check_value("req_error", dmem_pkg::word_t'(illegal), dmem_pkg::word_t'(req_error));
		if (!illegal) begin
			ref_store(wrap_addr(base_v, off_v), code, data); // written at the next edge
		end
		@(posedge clk);
		#1;
		check_value("load_valid", '0, dmem_pkg::word_t'(load_valid)); // stores give no load
	endtask

	task automatic do_load(input dmem_pkg::width_code_t code, input dmem_pkg::word_t base_v,
			input dmem_pkg::word_t off_v, input logic illegal);
		dmem_pkg::word_t expected;
		logic all_known;
		@(negedge clk);
		req_valid = 1'b1;
		req_store = 1'b0;
		funct3 = code;
		base = base_v;
		offset = off_v;
		ref_load(wrap_addr(base_v, off_v), code, expected, all_known);
		#1;
		check_value("req_error", dmem_pkg::word_t'(illegal), dmem_pkg::word_t'(req_error));
		@(posedge clk);
		#1;
		check_value("load_valid", dmem_pkg::word_t'(!illegal), dmem_pkg::word_t'(load_valid));
		if (!illegal && all_known) begin
			check_value("load_data", expected, load_data);
		end
	endtask

	task automatic test_aligned_words();
		for (int r = 0; r < 256; r += 37) begin
			do_store(3'd2, r * 4 + 64, -64, $urandom, 1'b0); // negative offset
		end
		for (int r = 0; r < 256; r += 37) begin
			do_load(3'd2, r * 4, 0, 1'b0);
			idle_cycles(1);
		end
		idle_cycles(2);
	endtask

	task automatic test_extension();
		do_store(3'd2, 32'h100, 0, 32'h80ff7f81, 1'b0);
		for (int b = 0; b < 4; b++) begin
			do_load(3'd0, 32'h100, b, 1'b0);
			do_load(3'd4, 32'h100, b, 1'b0);
		end
		for (int h = 0; h < 4; h += 2) begin
			do_load(3'd1, 32'h100, h, 1'b0);
			do_load(3'd5, 32'h100, h, 1'b0);
		end
		do_store(3'd0, 32'h100, 1, 32'h1234565a, 1'b0); // only byte 1
		do_load(3'd2, 32'h100, 0, 1'b0);
		do_store(3'd1, 32'h100, 2, 32'h9876a5c3, 1'b0); // only bytes 2 and 3
		do_load(3'd2, 32'h100, 0, 1'b0);
		idle_cycles(2);
	endtask

	task automatic test_unaligned();
		for (int k = 1; k < 4; k++) begin
			do_store(3'd2, 32'h200 + k * 8, k, $urandom, 1'b0);
		end
		for (int k = 1; k < 4; k++) begin
			do_load(3'd2, 32'h200 + k * 8, k, 1'b0);
		end
		do_store(3'd1, 32'h210, 3, 32'h0000c0de, 1'b0); // crosses a word boundary
		do_load(3'd1, 32'h210, 3, 1'b0);
		do_load(3'd5, 32'h210, 3, 1'b0);
		do_store(3'd2, 32'h3fe, 0, 32'hf00dcafe, 1'b0); // wraps past the top
		do_load(3'd2, 32'h3fe, 0, 1'b0);
		do_load(3'd1, 32'h3ff, 0, 1'b0);
		do_load(3'd2, 32'h7fe, 0, 1'b0);
		idle_cycles(2);
	endtask

	task automatic test_back_to_back();
		for (int k = 0; k < 6; k++) begin
			do_store(3'd2, 32'h300, k * 3, $urandom, 1'b0);
		end
		for (int k = 0; k < 6; k++) begin
			do_load(3'd2, 32'h300, k * 3, 1'b0);
		end
		do_store(3'd1, 32'h320, 1, 32'h0000b00b, 1'b0);
		do_load(3'd1, 32'h320, 1, 1'b0); // right after its store
		do_store(3'd2, 32'h323, 0, 32'h8badf00d, 1'b0);
		do_load(3'd2, 32'h323, 0, 1'b0);
		idle_cycles(2);
	endtask

	task automatic test_illegal();
		do_store(3'd2, 32'h50, 0, 32'h11223344, 1'b0);
		do_store(3'd4, 32'h50, 0, 32'hdeadbeef, 1'b1);
		do_store(3'd3, 32'h50, 0, 32'hdeadbeef, 1'b1);
		do_store(3'd7, 32'h50, 0, 32'hdeadbeef, 1'b1);
		do_load(3'd2, 32'h50, 0, 1'b0);
		do_load(3'd3, 32'h50, 0, 1'b1);
		idle_cycles(2);
	endtask

	task automatic test_random();
		dmem_pkg::width_code_t store_codes [3] = '{3'd0, 3'd1, 3'd2};
		dmem_pkg::width_code_t load_codes [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		dmem_pkg::word_t base_v;
		dmem_pkg::word_t off_v;
		for (int k = 0; k < 300; k++) begin
			base_v = 32'd1000 + $urandom_range(0, 31); // window runs over the top
			off_v = $urandom_range(0, 15);
			if ($urandom_range(0, 1) == 1) begin
				do_store(store_codes[$urandom_range(0, 2)], base_v, off_v, $urandom, 1'b0);
			end else begin
				do_load(load_codes[$urandom_range(0, 4)], base_v, off_v, 1'b0);
			end
		end
		idle_cycles(2);
	endtask

	initial begin
		void'($urandom(32'hc963));
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_store = 1'b0;
		funct3 = '0;
		base = '0;
		offset = '0;
		store_data = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("load_valid", '0, dmem_pkg::word_t'(load_valid));
		test_aligned_words();
		test_extension();
		test_unaligned();
		test_back_to_back();
		test_illegal();
		test_random();
		wait_load_idle();
		$display("test passed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+rtl
rtl/dmem_pkg.sv
rtl/mem_op_decode.sv
rtl/byte_bank.sv
rtl/striped_memory.sv
rtl/load_extend.sv
rtl/data_memory_unit.sv
tb/data_memory_unit_tb.sv
